// File: common/png_pkg.sv
package png_pkg;

    // Packet word and RAM port geometry
    localparam int WORD_W = 64;
    localparam int HALF_W = WORD_W / 2;    // One RAM port carries half a word
    localparam int KEEP_W = WORD_W / 8;    // One mask bit per byte
    localparam int INC_W  = 4;             // Holds 0..8 bytes per word

    // Buffer sizing
    localparam int ADDR_W    = 8;          // 256 half-words per buffer
    localparam int BUF_WORDS = 128;        // Two addresses per packet word
    localparam int WCNT_W    = 8;
    localparam int PLEN_W    = 16;         // Byte length of one packet

    localparam int NUM_BUFS  = 3;          // Ping, pang and pong
    localparam int BUF_IDX_W = 2;

    // Optional pipeline registers around each buffer RAM
    localparam int PNG_BUF_IN  = 0;
    localparam int PNG_BUF_OUT = 1;
    localparam int RD_LAT      = 1 + PNG_BUF_IN + PNG_BUF_OUT;  // Read to data, in cycles

    // Egress flow control
    localparam int CREDIT_MAX = 8;
    localparam int CREDIT_W   = 4;

    localparam int DROP_W = 16;

    // Life cycle of one buffer
    typedef enum logic [1:0] {
        BUF_FREE,                          // Available for a new packet
        BUF_FILL,                          // Packet being written
        BUF_READY,                         // Complete, waiting in the ready queue
        BUF_DRAIN                          // Being read out
    } buf_state_e;

    // Egress sequencer
    typedef enum logic [1:0] {
        EG_IDLE,
        EG_READ,
        EG_CLEAR
    } egress_state_e;

endpackage

// File: png_buffer/dp_bram.sv
`timescale 1ns/1ps

// Two-port RAM meant to map onto one block RAM
// Both ports share the enable and the write strobe
module dp_bram #(
    parameter int ADDR_W = 8,
    parameter int HALF_W = 32
) (
    input  logic              clk,
    input  logic              en_i,       // Port enable for read or write
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] addra_i,
    input  logic [ADDR_W-1:0] addrb_i,
    input  logic [HALF_W-1:0] dia_i,
    input  logic [HALF_W-1:0] dib_i,
    output logic [HALF_W-1:0] doa_o,      // One cycle after the address
    output logic [HALF_W-1:0] dob_o
);

    logic [HALF_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (wr_en_i) mem[addra_i] <= dia_i;
            doa_o <= mem[addra_i];       // Read-first, old contents come out
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (wr_en_i) mem[addrb_i] <= dib_i;
            dob_o <= mem[addrb_i];       // Read-first
        end
    end

endmodule

// File: png_buffer/p_ng.sv
`timescale 1ns/1ps

// One of the ping, pang and pong packet buffers
// A word is stored as two halves at addr and addr+1
module p_ng
    import png_pkg::*;
#(
    parameter int BUF_IN  = 0,           // Register the inputs for a cycle
    parameter int BUF_OUT = 0            // Register the read data for a cycle
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear_i,   // Zeroes the byte length
    input  logic              rd_en_i,
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [WORD_W-1:0] idata_i,
    input  logic [INC_W-1:0]  byte_inc_i,
    output logic [WORD_W-1:0] odata_o,   // 1 + BUF_IN + BUF_OUT cycles after rd_en_i
    output logic [PLEN_W-1:0] byte_length_o
);

    logic              rd_en_q;
    logic              wr_en_q;
    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] idata_q;
    logic [WORD_W-1:0] odata_m;          // Raw RAM output
    logic [PLEN_W-1:0] byte_len;

    // Length follows the unregistered strobe, so it is valid the cycle after the last write
    always_ff @(posedge clk) begin
        if (!rst || clear_i) byte_len <= '0;
        else if (wr_en_i)    byte_len <= byte_len + PLEN_W'(byte_inc_i);
    end
    assign byte_length_o = byte_len;

    if (BUF_IN != 0) begin : g_in_reg
        always_ff @(posedge clk) begin
            if (!rst) begin
                rd_en_q <= 1'b0;
                wr_en_q <= 1'b0;
            end else begin
                rd_en_q <= rd_en_i;
                wr_en_q <= wr_en_i;
            end
        end
        always_ff @(posedge clk) begin
            addr_q  <= addr_i;
            idata_q <= idata_i;
        end
    end else begin : g_in_wire
        assign rd_en_q = rd_en_i;
        assign wr_en_q = wr_en_i;
        assign addr_q  = addr_i;
        assign idata_q = idata_i;
    end

    dp_bram #(.ADDR_W(ADDR_W), .HALF_W(HALF_W)) u_mem (
        .clk     (clk),
        .en_i    (rd_en_q || wr_en_q),
        .wr_en_i (wr_en_q),
        .addra_i (addr_q),                       // Upper half
        .addrb_i (addr_q + ADDR_W'(1)),          // Lower half on the next address
        .dia_i   (idata_q[WORD_W-1:HALF_W]),
        .dib_i   (idata_q[HALF_W-1:0]),
        .doa_o   (odata_m[WORD_W-1:HALF_W]),
        .dob_o   (odata_m[HALF_W-1:0])
    );

    if (BUF_OUT != 0) begin : g_out_reg
        always_ff @(posedge clk) odata_o <= odata_m;
    end else begin : g_out_wire
        assign odata_o = odata_m;
    end

    // Word writes land on even addresses so the two halves never overlap the next word
    a_even_addr: assert property (@(posedge clk) disable iff (!rst) wr_en_q |-> !addr_q[0]);

endmodule

// File: rtl/ingress_decode.sv
`timescale 1ns/1ps

// Decode stage, frames snooper words and forms the buffer write
// Every output follows its input word by one cycle
module ingress_decode
    import png_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid_i,
    input  logic              in_last_i,
    input  logic [WORD_W-1:0] in_data_i,
    input  logic [KEEP_W-1:0] in_keep_i,
    output logic              wr_en_o,
    output logic              pkt_start_o,
    output logic              pkt_end_o,
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [WORD_W-1:0] wr_data_o,
    output logic [INC_W-1:0]  byte_inc_o
);

    logic              in_pkt;           // A packet has started and not yet ended
    logic [WCNT_W-1:0] wcnt;             // Index of the next word, saturates at capacity
    logic              first;
    logic [WCNT_W-1:0] widx;             // Index of the current word
    logic              fits;

    assign first = !in_pkt;
    assign widx  = first ? '0 : wcnt;
    assign fits  = (widx < WCNT_W'(BUF_WORDS));    // Overflow words are not stored

    always_ff @(posedge clk) begin
        if (!rst) begin
            in_pkt      <= 1'b0;
            wcnt        <= '0;
            wr_en_o     <= 1'b0;
            pkt_start_o <= 1'b0;
            pkt_end_o   <= 1'b0;
        end else begin
            wr_en_o     <= in_valid_i && fits;
            pkt_start_o <= in_valid_i && first;
            pkt_end_o   <= in_valid_i && in_last_i;   // Sent even for a truncated word
            if (in_valid_i) begin
                in_pkt <= !in_last_i;
                if (fits) wcnt <= widx + 1'b1;
                else      wcnt <= widx;               // Hold at capacity
            end
        end
    end

    // Payload side, no reset
    always_ff @(posedge clk) begin
        wr_addr_o  <= {widx[ADDR_W-2:0], 1'b0};      // Two half-words per word
        wr_data_o  <= in_data_i;
        byte_inc_o <= INC_W'($countones(in_keep_i));
    end

    // Partial masks belong only to the end of a packet
    a_keep_last: assert property (@(posedge clk) disable iff (!rst)
        (in_valid_i && (in_keep_i != '1)) |-> in_last_i);

endmodule

// File: rtl/buffer_rotator.sv
`timescale 1ns/1ps

// Execute stage, owns the three buffers and rotates them through
// free, fill, ready and drain
module buffer_rotator
    import png_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en_i,
    input  logic              pkt_start_i,
    input  logic              pkt_end_i,
    input  logic              grant_take_i,
    input  logic              rd_en_i,
    input  logic              drain_done_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    input  logic [WORD_W-1:0] wr_data_i,
    input  logic [INC_W-1:0]  byte_inc_i,
    output logic              grant_valid_o,
    output logic [PLEN_W-1:0] grant_len_o,
    output logic [WORD_W-1:0] rd_data_o,
    output logic [DROP_W-1:0] drop_count_o
);

    buf_state_e           buf_state [NUM_BUFS];
    logic [NUM_BUFS-1:0]  fill_vec;
    logic [WORD_W-1:0]    odata [NUM_BUFS];
    logic [PLEN_W-1:0]    blen  [NUM_BUFS];

    logic [BUF_IDX_W-1:0] fill_idx;      // Buffer taking the current packet
    logic [BUF_IDX_W-1:0] drain_idx;     // Buffer being read out
    logic                 dropping;      // Current packet found no free buffer
    logic [BUF_IDX_W-1:0] alloc_idx;
    logic                 any_free;
    logic [BUF_IDX_W-1:0] cur_idx;       // Buffer this word goes to
    logic                 cur_ok;        // This word has a buffer at all

    // Ready queue, head at entry 0, in completion order
    logic [BUF_IDX_W-1:0] q_idx [NUM_BUFS];
    logic [1:0]           q_cnt;
    logic [1:0]           push_pos;
    logic                 push;
    logic                 pop;

    // Lowest free index wins
    always_comb begin
        any_free  = 1'b0;
        alloc_idx = '0;
        for (int b = NUM_BUFS - 1; b >= 0; b--) begin
            if (buf_state[b] == BUF_FREE) begin
                any_free  = 1'b1;
                alloc_idx = BUF_IDX_W'(b);
            end
        end
    end

    assign cur_idx  = pkt_start_i ? alloc_idx : fill_idx;
    assign cur_ok   = pkt_start_i ? any_free : !dropping;
    assign push     = cur_ok && pkt_end_i;
    assign pop      = grant_take_i;
    assign push_pos = q_cnt - {1'b0, pop};   // Slot after any shift this cycle

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int b = 0; b < NUM_BUFS; b++) buf_state[b] <= BUF_FREE;
            fill_idx     <= '0;
            drain_idx    <= '0;
            dropping     <= 1'b0;
            drop_count_o <= '0;
            q_cnt        <= '0;
        end else begin
            q_cnt <= q_cnt + {1'b0, push} - {1'b0, pop};
            if (pkt_start_i) begin
                dropping <= !any_free && !pkt_end_i;
                if (any_free) fill_idx <= alloc_idx;
                else          drop_count_o <= drop_count_o + 1'b1;   // Once per lost packet
            end else if (pkt_end_i) begin
                dropping <= 1'b0;
            end
            if (cur_ok && (pkt_start_i || pkt_end_i))
                buf_state[cur_idx] <= pkt_end_i ? BUF_READY : BUF_FILL;  // One-word packets skip fill
            if (grant_take_i) begin
                buf_state[q_idx[0]] <= BUF_DRAIN;
                drain_idx           <= q_idx[0];
            end
            if (drain_done_i) buf_state[drain_idx] <= BUF_FREE;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < NUM_BUFS - 1; i++) q_idx[i] <= q_idx[i+1];
        end
        if (push) q_idx[push_pos] <= cur_idx;
    end

    assign grant_valid_o = (q_cnt != '0);
    assign grant_len_o   = blen[q_idx[0]];
    assign rd_data_o     = odata[drain_idx];

    for (genvar b = 0; b < NUM_BUFS; b++) begin : g_buf
        logic sel_rd;
        assign sel_rd      = (drain_idx == BUF_IDX_W'(b));
        assign fill_vec[b] = (buf_state[b] == BUF_FILL);

        p_ng #(.BUF_IN(PNG_BUF_IN), .BUF_OUT(PNG_BUF_OUT)) u_png (
            .clk           (clk),
            .rst           (rst),
            .clear_i       (drain_done_i && sel_rd),
            .rd_en_i       (rd_en_i && sel_rd),
            .wr_en_i       (wr_en_i && cur_ok && (cur_idx == BUF_IDX_W'(b))),
            .addr_i        ((rd_en_i && sel_rd) ? rd_addr_i : wr_addr_i),
            .idata_i       (wr_data_i),
            .byte_inc_i    (byte_inc_i),
            .odata_o       (odata[b]),
            .byte_length_o (blen[b])
        );
    end

    // Egress may only take a buffer that the queue offers
    a_take_valid: assert property (@(posedge clk) disable iff (!rst)
        grant_take_i |-> grant_valid_o);
    a_one_fill:   assert property (@(posedge clk) disable iff (!rst) $onehot0(fill_vec));

endmodule

// File: rtl/egress_result.sv
`timescale 1ns/1ps

// Result stage, drains one granted buffer at a time toward the consumer
// Reads go out only while a credit is left over after the reads in flight
module egress_result
    import png_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              grant_valid_i,
    input  logic              credit_i,
    input  logic [PLEN_W-1:0] grant_len_i,
    input  logic [WORD_W-1:0] rd_data_i,
    output logic              grant_take_o,
    output logic              rd_en_o,
    output logic              drain_done_o,
    output logic              out_valid_o,
    output logic              out_last_o,
    output logic [ADDR_W-1:0] rd_addr_o,
    output logic [WORD_W-1:0] out_data_o,
    output logic [KEEP_W-1:0] out_keep_o
);

    egress_state_e     state;
    logic [WCNT_W-1:0] rd_cnt;           // Next word to read
    logic [WCNT_W-1:0] last_idx;         // Index of the final word
    logic [KEEP_W-1:0] last_keep;        // Mask of the final word
    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] inflight;       // Reads not yet out, output stage included
    logic [RD_LAT-1:0] vld_sr;           // One tap per cycle of read latency
    logic [RD_LAT-1:0] last_sr;
    logic [PLEN_W-1:0] len_m1;

    always_comb begin
        inflight = '0;
        for (int i = 0; i < RD_LAT; i++) inflight = inflight + CREDIT_W'(vld_sr[i]);
    end

    assign len_m1       = grant_len_i - 1'b1;
    assign grant_take_o = (state == EG_IDLE) && grant_valid_i;
    assign rd_en_o      = (state == EG_READ) && (credits > inflight);
    assign rd_addr_o    = {rd_cnt[ADDR_W-2:0], 1'b0};
    assign drain_done_o = (state == EG_CLEAR) && (inflight == '0);   // Final word has left

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= EG_IDLE;
            rd_cnt  <= '0;
            credits <= '0;
            vld_sr  <= '0;
            last_sr <= '0;
        end else begin
            vld_sr  <= RD_LAT'({vld_sr, rd_en_o});
            last_sr <= RD_LAT'({last_sr, rd_en_o && (rd_cnt == last_idx)});
            credits <= credits + CREDIT_W'(credit_i) - CREDIT_W'(out_valid_o);
            case (state)
                EG_IDLE: if (grant_valid_i) begin
                    state  <= EG_READ;
                    rd_cnt <= '0;
                end
                EG_READ: if (rd_en_o) begin
                    rd_cnt <= rd_cnt + 1'b1;
                    if (rd_cnt == last_idx) state <= EG_CLEAR;
                end
                EG_CLEAR: if (drain_done_o) state <= EG_IDLE;
                default: state <= EG_IDLE;
            endcase
        end
    end

    // Word count and final mask from the granted length, empty packet gives one blank word
    always_ff @(posedge clk) begin
        if (grant_take_o) begin
            last_idx <= (grant_len_i == '0) ? '0 : WCNT_W'(len_m1 >> 3);
            if (grant_len_i == '0)           last_keep <= '0;
            else if (grant_len_i[2:0] == '0) last_keep <= '1;
            else                             last_keep <= ~(8'hff >> grant_len_i[2:0]);
        end
    end

    assign out_valid_o = vld_sr[RD_LAT-1];
    assign out_last_o  = last_sr[RD_LAT-1];
    assign out_data_o  = rd_data_i;                    // Arrives with the last tap
    assign out_keep_o  = out_last_o ? last_keep : '1;

    // Downstream must not return more credits than the stage can hold
    a_credit_max: assert property (@(posedge clk) disable iff (!rst)
        credits <= CREDIT_W'(CREDIT_MAX));

endmodule

// File: rtl/png_capture_top.sv
`timescale 1ns/1ps

// Packet capture top, decode then execute then result
module png_capture_top
    import png_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid_i,
    input  logic              in_last_i,
    input  logic              credit_i,
    input  logic [WORD_W-1:0] in_data_i,
    input  logic [KEEP_W-1:0] in_keep_i,
    output logic              out_valid_o,
    output logic              out_last_o,
    output logic [WORD_W-1:0] out_data_o,
    output logic [KEEP_W-1:0] out_keep_o,
    output logic [DROP_W-1:0] drop_count_o
);

    // Decode to execute
    logic wr_en, pkt_start, pkt_end;
    logic [ADDR_W-1:0] wr_addr;
    logic [WORD_W-1:0] wr_data;
    logic [INC_W-1:0]  byte_inc;

    // Execute to result
    logic grant_valid, grant_take, rd_en, drain_done;
    logic [PLEN_W-1:0] grant_len;
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] rd_data;

    ingress_decode u_decode (
        .clk, .rst, .in_valid_i, .in_last_i, .in_data_i, .in_keep_i,
        .wr_en_o(wr_en), .pkt_start_o(pkt_start), .pkt_end_o(pkt_end),
        .wr_addr_o(wr_addr), .wr_data_o(wr_data), .byte_inc_o(byte_inc)
    );

    buffer_rotator u_rotator (
        .clk, .rst, .wr_en_i(wr_en), .pkt_start_i(pkt_start), .pkt_end_i(pkt_end),
        .grant_take_i(grant_take), .rd_en_i(rd_en), .drain_done_i(drain_done),
        .wr_addr_i(wr_addr), .rd_addr_i(rd_addr), .wr_data_i(wr_data),
        .byte_inc_i(byte_inc), .grant_valid_o(grant_valid), .grant_len_o(grant_len),
        .rd_data_o(rd_data), .drop_count_o
    );

    egress_result u_result (
        .clk, .rst, .grant_valid_i(grant_valid), .credit_i, .grant_len_i(grant_len),
        .rd_data_i(rd_data), .grant_take_o(grant_take), .rd_en_o(rd_en),
        .drain_done_o(drain_done), .out_valid_o, .out_last_o, .rd_addr_o(rd_addr),
        .out_data_o, .out_keep_o
    );

endmodule

// File: tb/tb_png_capture.sv
`timescale 1ns/1ps

// Testbench for the ping/pang/pong capture stage
module tb_png_capture
    import png_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RST_CYCLES      = 10;
    localparam int TOTAL_WORDS     = 4 * 6 + 5 + 20 * 16 + BUF_WORDS + 4;  // Sum over all tests
    localparam int CYCLES_PER_WORD = 40;     // Covers gaps, credit stalls and drain waits
    localparam int WATCHDOG_NS     = (TOTAL_WORDS * CYCLES_PER_WORD + 500) * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              in_valid_i;
    logic              in_last_i;
    logic              credit_i = 1'b0;
    logic [WORD_W-1:0] in_data_i;
    logic [KEEP_W-1:0] in_keep_i;
    logic              out_valid_o;
    logic              out_last_o;
    logic [WORD_W-1:0] out_data_o;
    logic [KEEP_W-1:0] out_keep_o;
    logic [DROP_W-1:0] drop_count_o;

    integer seed = 32'hb133_f3e3;
    string  test_name = "reset";

    logic [WORD_W-1:0] pkt_words [BUF_WORDS+4];  // Payload of the packet being sent
    logic [WORD_W-1:0] exp_data [$];             // Expected words in output order
    logic [KEEP_W-1:0] exp_keep [$];
    logic              exp_last [$];
    int                pkts_open = 0;            // Accepted, last word not yet out
    int                credit_mirror = 0;        // Copy of the DUT credit count
    logic              credit_en = 1'b0;
    logic              credit_rand = 1'b0;       // Return credits at random
    logic [WORD_W-1:0] cur_data;
    logic [KEEP_W-1:0] cur_keep;
    logic              cur_last;

    png_capture_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic halt_with_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    // Mask with the given number of upper bytes set
    function automatic logic [KEEP_W-1:0] keep_for(input int bytes);
        logic [KEEP_W-1:0] mask;
        mask = '0;
        for (int b = 0; b < bytes && b < KEEP_W; b++) mask[KEEP_W-1-b] = 1'b1;  // MSB first
        return mask;
    endfunction

    // Reference model, applies drop and truncation to the packet in pkt_words
    function automatic void expect_packet(input int n_words, input int last_bytes,
                                          input bit dropped);
        int kept;
        int byte_len;
        if (dropped) return;                     // Whole packet lost
        kept     = (n_words > BUF_WORDS) ? BUF_WORDS : n_words;
        byte_len = 0;
        for (int i = 0; i < kept; i++)
            byte_len += (i == n_words - 1) ? last_bytes : KEEP_W;
        for (int i = 0; i < kept; i++) begin
            exp_data.push_back(pkt_words[i]);
            if (i == kept - 1)
                exp_keep.push_back(keep_for((byte_len % 8 == 0) ? 8 : byte_len % 8));
            else
                exp_keep.push_back({KEEP_W{1'b1}});
            exp_last.push_back(i == kept - 1);
        end
        pkts_open++;
    endfunction

    // One packet, one word per cycle, no back-pressure
    task automatic send_packet(input int n_words, input int last_bytes, input bit wait_free);
        bit dropped;
        if (wait_free) begin
            while (pkts_open >= NUM_BUFS) @(posedge clk);
            repeat (4) @(posedge clk);           // Let the drained buffer come free
        end
        for (int i = 0; i < n_words; i++) pkt_words[i] = {$random(seed), $random(seed)};
        dropped = (pkts_open >= NUM_BUFS);       // Every buffer still held
        expect_packet(n_words, last_bytes, dropped);
        for (int i = 0; i < n_words; i++) begin
            @(posedge clk);
            in_valid_i <= 1'b1;
            in_data_i  <= pkt_words[i];
            in_last_i  <= (i == n_words - 1);
            in_keep_i  <= (i == n_words - 1) ? keep_for(last_bytes) : '1;
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
        in_last_i  <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_data.size() != 0) @(posedge clk);  // Watchdog bounds this
        repeat (8) @(posedge clk);
    endtask

    // Credit driver, never more than CREDIT_MAX outstanding
    always @(posedge clk) begin
        if (!rst) begin
            credit_mirror = 0;
            credit_i <= 1'b0;
        end else begin
            credit_mirror = credit_mirror + int'(credit_i) - int'(out_valid_o);
            credit_i <= credit_en && (credit_mirror < CREDIT_MAX) &&
                        (!credit_rand || (($random(seed) & 1) != 0));
        end
    end

    // Scoreboard, values sampled before the edge updates them
    always @(posedge clk) begin
        if (rst && out_valid_o) begin
            if (exp_data.size() == 0) begin
                halt_with_error("Output word appeared while no packet was expected");
            end else begin
                cur_data = exp_data.pop_front();
                cur_keep = exp_keep.pop_front();
                cur_last = exp_last.pop_front();
                assert (out_data_o == cur_data) else halt_with_error($sformatf(
                    "FAIL %s: out_data expected %h actual %h", test_name, cur_data, out_data_o));
                assert (out_keep_o == cur_keep) else halt_with_error($sformatf(
                    "FAIL %s: out_keep expected %h actual %h", test_name, cur_keep, out_keep_o));
                assert (out_last_o == cur_last) else halt_with_error($sformatf(
                    "FAIL %s: out_last expected %0b actual %0b", test_name, cur_last,
                    out_last_o));
                if (cur_last) pkts_open--;
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run timed out before all packets came out");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        int n_words;
        int last_bytes;
        rst        <= 1'b0;
        in_valid_i <= 1'b0;
        in_last_i  <= 1'b0;
        in_data_i  <= '0;
        in_keep_i  <= '1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;

        test_name = "idle_after_reset";                // Credits still held back
        repeat (20) begin
            @(posedge clk);
            assert (!out_valid_o) else halt_with_error("Output valid rose with no input");
        end
        assert (drop_count_o == '0) else halt_with_error($sformatf(
            "FAIL %s: drop_count expected 0 actual %0d", test_name, drop_count_o));

        // Three packets hold every buffer, the fourth finds none
        test_name = "drop_when_full";
        send_packet(6, 2, 1'b0);
        send_packet(6, 7, 1'b0);
        send_packet(6, 8, 1'b0);
        send_packet(6, 4, 1'b0);                      // Dropped whole
        repeat (3) @(posedge clk);
        assert (drop_count_o == DROP_W'(1)) else halt_with_error($sformatf(
            "FAIL %s: drop_count expected 1 actual %0d", test_name, drop_count_o));
        repeat (20) begin
            @(posedge clk);
            assert (!out_valid_o) else halt_with_error("Output appeared without credits");
        end
        credit_en <= 1'b1;
        wait_drained();

        test_name = "single_packet";
        send_packet(5, 3, 1'b0);                      // Last mask is three upper bytes
        wait_drained();

        test_name = "random_packets";
        credit_rand <= 1'b1;
        repeat (20) begin
            n_words    = 1 + ($random(seed) & 15);
            last_bytes = 1 + ($random(seed) & 7);
            send_packet(n_words, last_bytes, 1'b1);
            repeat ($unsigned($random(seed)) % 6) @(posedge clk);   // Gap between packets
        end
        wait_drained();
        credit_rand <= 1'b0;

        test_name = "truncate";
        send_packet(BUF_WORDS + 4, 5, 1'b0);          // Four words past capacity
        wait_drained();

        test_name = "end_of_run";
        repeat (20) @(posedge clk);
        if (exp_data.size() == 0 && drop_count_o == DROP_W'(1)) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            halt_with_error("Expected words left over or drop count changed at end of run");
        end
    end

endmodule

// File: all.f
common/png_pkg.sv
png_buffer/dp_bram.sv
png_buffer/p_ng.sv
rtl/ingress_decode.sv
rtl/buffer_rotator.sv
rtl/egress_result.sv
rtl/png_capture_top.sv
tb/tb_png_capture.sv

// File: Makefile
TOP = tb_png_capture

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f all.f -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module png_capture_top \
		common/png_pkg.sv png_buffer/dp_bram.sv png_buffer/p_ng.sv \
		rtl/ingress_decode.sv rtl/buffer_rotator.sv rtl/egress_result.sv \
		rtl/png_capture_top.sv

clean:
	rm -rf obj_dir sim.log
